//--- rob_stimulus.txt
# D label inst pc tag | N label count inst pc first_tag | A/L label value addr exc cause
# R label target | C rd reg_write mem_write value addr | T epc cause | M | F full
D 01 00000093 00001000 0
D 02 00000113 00001004 1
D 03 00000283 00001008 2
D 04 00000023 0000100c 3
D 05 00000013 00001010 4
L 04 00000000 00002000 0 0
L 03 00000055 00003000 0 0
A 02 00000022 00000000 0 0
A 01 00000011 00000000 0 0
C 01 1 0 00000011 00000000
C 02 1 0 00000022 00000000
C 05 1 0 00000055 00003000
C 00 0 1 00000000 00002000
A 05 00000099 00000000 0 0
C 00 1 0 00000099 00000000
N 10 10 00000093 00002000 5
F 1
A 10 000000aa 00000000 0 0
C 01 1 0 000000aa 00000000
F 0
A 11 00000000 00000000 1 1
T 00002004 1
D 20 00000193 00003000 0
D 21 00000063 00003004 1
D 22 00000093 00003008 2
D 23 00000113 0000300c 3
A 22 00000077 00000000 0 0
R 21 00004000
A 20 00000033 00000000 0 0
C 03 1 0 00000033 00000000
C 00 0 0 00004000 00000000
D 24 00000293 00004000 2
L 24 00000abc 00005000 0 0
C 05 1 0 00000abc 00005000
D 25 30200073 00004004 3
D 26 0000007f 00004008 4
M
T 00004008 0
D 27 00000013 00005000 0
A 27 00000001 00000000 0 0
C 00 1 0 00000001 00000000

//--- project.f
rob_pkg.sv
dispatch_unit.sv
rob_buffer.sv
commit_unit.sv
rob_core_top.sv
tb_rob_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status is the verdict
verilator --binary --timing --assert -Wall -Wno-fatal --top-module tb_rob_core \
    -f project.f -o sim_rob \
    && ./obj_dir/sim_rob \
    || exit 1

//--- tb_rob_core.sv
`default_nettype none

module tb_rob_core;

    logic                      clk;
    logic                      rst;
    logic                      inst_valid;
    logic [rob_pkg::XLEN-1:0]  inst;
    logic [rob_pkg::XLEN-1:0]  pc;
    rob_pkg::exec_result_t     alu_result;
    rob_pkg::exec_result_t     lsu_result;
    rob_pkg::redirect_t        redirect;
    logic [rob_pkg::TAG_W-1:0] alloc_tag;
    logic                      rob_full;
    rob_pkg::commit_t          commit;
    logic                      trap;
    logic [rob_pkg::XLEN-1:0]  epc;
    rob_pkg::cause_e           cause;
    logic                      mret;

    string                     lines[$];            // Stimulus records without comment lines
    rob_pkg::tag_t             tag_of [256];        // Tag recorded per sequence label
    int                        cycles;
    int                        limit;

    // Retirement events seen at the outputs (kind 0 commit, 1 trap, 2 mret)
    int                        ev_kind[$];
    rob_pkg::commit_t          ev_commit[$];
    logic [rob_pkg::XLEN-1:0]  ev_epc[$];
    rob_pkg::cause_e           ev_cause[$];

    rob_core_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .alu_result (alu_result),
        .lsu_result (lsu_result),
        .redirect   (redirect),
        .alloc_tag  (alloc_tag),
        .rob_full   (rob_full),
        .commit     (commit),
        .trap       (trap),
        .epc        (epc),
        .cause      (cause),
        .mret       (mret)
    );

    always #5 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles waiting for the DUT", cycles);
            $display("Something failed");
            $fatal(1);
        end
    end

    // Registered outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (commit.valid) begin
                ev_kind.push_back(0);
                ev_commit.push_back(commit);
                ev_epc.push_back('0);
                ev_cause.push_back(rob_pkg::CAUSE_ILLEGAL);
            end
            if (trap) begin
                ev_kind.push_back(1);
                ev_commit.push_back('0);
                ev_epc.push_back(epc);
                ev_cause.push_back(cause);
            end
            if (mret) begin
                ev_kind.push_back(2);
                ev_commit.push_back('0);
                ev_epc.push_back('0);
                ev_cause.push_back(rob_pkg::CAUSE_ILLEGAL);
            end
        end
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_commit(input string name, input rob_pkg::commit_t exp,
                                input rob_pkg::commit_t act);
        if (exp !== act) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_trap(input string name,
                              input logic [rob_pkg::XLEN-1:0] exp_epc,
                              input rob_pkg::cause_e exp_cause,
                              input logic [rob_pkg::XLEN-1:0] act_epc,
                              input rob_pkg::cause_e act_cause);
        if (exp_epc !== act_epc || exp_cause !== act_cause) begin
            $display("Mismatch %s expected epc %h cause %0d actual epc %h cause %0d",
                     name, exp_epc, exp_cause, act_epc, act_cause);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_tag(input string name, input logic [rob_pkg::TAG_W-1:0] exp,
                             input logic [rob_pkg::TAG_W-1:0] act);
        if (exp !== act) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Mismatch %s expected %b actual %b", name, exp, act);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // One clock, then idle strobes
    task automatic next_cycle();
        @(posedge clk);
        #1;
        inst_valid       = 1'b0;
        alu_result.done  = 1'b0;
        lsu_result.done  = 1'b0;
        redirect.valid   = 1'b0;
    endtask

    task automatic dispatch(input string name, input logic [7:0] label,
                            input logic [31:0] word, input logic [31:0] addr,
                            input rob_pkg::tag_t exp_tag);
        inst_valid = 1'b1;
        inst       = word;
        pc         = addr;
        #1;                                 // Tag is combinational
        tag_of[label] = alloc_tag;
        check_tag(name, exp_tag, alloc_tag);
        next_cycle();
    endtask

    task automatic pop_event(input string name, input int kind);
        while (ev_kind.size() == 0) begin
            @(posedge clk);
            #1;
        end
        if (ev_kind[0] != kind) begin
            fail_now($sformatf("%s expected event kind %0d but saw kind %0d",
                               name, kind, ev_kind[0]));
        end
    endtask

    task automatic run_record(input int idx, input string line);
        logic [7:0]       k;
        logic [31:0]      a;
        logic [31:0]      b;
        logic [31:0]      c;
        logic [31:0]      d;
        logic [31:0]      e;
        string            name;
        rob_pkg::commit_t exp_c;
        void'($sscanf(line, "%c %h %h %h %h %h", k, a, b, c, d, e));
        name = $sformatf("record %0d (%s)", idx, line.substr(0, 0));
        case (k)
            "D": dispatch(name, a[7:0], b, c, rob_pkg::tag_t'(d));
            "N": begin
                for (int i = 0; i < int'(b); i++) begin
                    dispatch(name, a[7:0] + 8'(i), c, d + 32'(4 * i),
                             rob_pkg::tag_t'(e + 32'(i)));  // Wraps modulo depth
                end
            end
            "A", "L": begin
                rob_pkg::exec_result_t r;
                r.done      = 1'b1;
                r.tag       = tag_of[a[7:0]];
                r.value     = b;
                r.addr      = c;
                r.exception = d[0];
                r.cause     = rob_pkg::cause_e'(e[1:0]);
                if (k == "A") alu_result = r;
                else lsu_result = r;
                next_cycle();
            end
            "R": begin
                redirect.valid  = 1'b1;
                redirect.tag    = tag_of[a[7:0]];
                redirect.target = b;
                next_cycle();
            end
            "C": begin
                exp_c.valid     = 1'b1;
                exp_c.rd        = a[4:0];
                exp_c.reg_write = b[0];
                exp_c.mem_write = c[0];
                exp_c.value     = d;
                exp_c.addr      = e;
                pop_event(name, 0);
                check_commit(name, exp_c, ev_commit[0]);
                void'(ev_kind.pop_front());
                void'(ev_commit.pop_front());
                void'(ev_epc.pop_front());
                void'(ev_cause.pop_front());
            end
            "T": begin
                pop_event(name, 1);
                check_trap(name, a, rob_pkg::cause_e'(b[1:0]), ev_epc[0], ev_cause[0]);
                void'(ev_kind.pop_front());
                void'(ev_commit.pop_front());
                void'(ev_epc.pop_front());
                void'(ev_cause.pop_front());
            end
            "M": begin
                pop_event(name, 2);
                void'(ev_kind.pop_front());
                void'(ev_commit.pop_front());
                void'(ev_epc.pop_front());
                void'(ev_cause.pop_front());
            end
            "F": check_flag(name, a[0], rob_full);
            default: fail_now($sformatf("Unknown record kind in line: %s", line));
        endcase
    endtask

    initial begin
        int    fd;
        int    nrec;
        string line;
        logic [7:0]  k;
        logic [31:0] a;
        logic [31:0] b;
        clk        = 1'b0;
        rst        = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        pc         = '0;
        alu_result = '0;
        lsu_result = '0;
        redirect   = '0;
        cycles     = 0;
        limit      = 0;
        nrec       = 0;
        fd = $fopen("rob_stimulus.txt", "r");
        if (fd == 0) begin
            fail_now("Cannot open rob_stimulus.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                lines.push_back(line);
                if ($sscanf(line, "%c %h %h", k, a, b) == 3 && k == "N") nrec += int'(b);
                else nrec++;
            end
        end
        $fclose(fd);
        limit = 4 * nrec + 50;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (lines[i]) begin
            run_record(i, lines[i]);
        end
        repeat (5) next_cycle();                   // Catch late wrong-path retirements
        if (ev_kind.size() != 0) begin
            $display("Unexpected retirement after the last expected record");
            $display("Something failed");
            $fatal(1);
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- rob_core_top.sv
`default_nettype none

module rob_core_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       inst_valid,
    input  logic [rob_pkg::XLEN-1:0]   inst,
    input  logic [rob_pkg::XLEN-1:0]   pc,
    input  rob_pkg::exec_result_t      alu_result,
    input  rob_pkg::exec_result_t      lsu_result,
    input  rob_pkg::redirect_t         redirect,
    output logic [rob_pkg::TAG_W-1:0]  alloc_tag,
    output logic                       rob_full,
    output rob_pkg::commit_t           commit,
    output logic                       trap,
    output logic [rob_pkg::XLEN-1:0]   epc,
    output rob_pkg::cause_e            cause,
    output logic                       mret
);

    logic                alloc_valid;  // Dispatch into buffer
    rob_pkg::rob_entry_t alloc_entry;
    rob_pkg::rob_entry_t head_entry;   // Oldest slot to commit
    logic                retire;       // Commit pops head
    logic                flush_all;    // Trap clears buffer

    dispatch_unit dispatch_i (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .pc          (pc),
        .rob_full    (rob_full),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry)
    );

    rob_buffer buffer_i (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_entry (alloc_entry),
        .alu_result  (alu_result),
        .lsu_result  (lsu_result),
        .redirect    (redirect),
        .retire      (retire),
        .flush_all   (flush_all),
        .alloc_tag   (alloc_tag),
        .rob_full    (rob_full),
        .head_entry  (head_entry)
    );

    commit_unit commit_i (
        .clk        (clk),
        .rst        (rst),
        .head_entry (head_entry),
        .retire     (retire),
        .flush_all  (flush_all),
        .commit     (commit),
        .trap       (trap),
        .epc        (epc),
        .cause      (cause),
        .mret       (mret)
    );

endmodule

`default_nettype wire

//--- commit_unit.sv
`default_nettype none

module commit_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  rob_pkg::rob_entry_t       head_entry,
    output logic                      retire,
    output logic                      flush_all,
    output rob_pkg::commit_t          commit,
    output logic                      trap,
    output logic [rob_pkg::XLEN-1:0]  epc,
    output rob_pkg::cause_e           cause,
    output logic                      mret
);

    logic [rob_pkg::XLEN-1:0] arf [32];  // Architectural register file
    logic                     is_mret;   // Head is a clean mret
    logic                     is_normal; // Head writes back or stores

    assign retire    = head_entry.busy && head_entry.ready;
    assign flush_all = retire && head_entry.exception;  // Trap empties the buffer
    assign is_mret   = retire && !head_entry.exception &&
                       (head_entry.opcode == rob_pkg::OP_MRET);
    assign is_normal = retire && !head_entry.exception &&
                       (head_entry.opcode != rob_pkg::OP_MRET);

    always_ff @(posedge clk) begin
        if (rst) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= is_normal;                 // One cycle per retired entry
            if (is_normal) begin
                commit.rd        <= head_entry.rd;
                commit.reg_write <= head_entry.reg_write;
                commit.mem_write <= head_entry.mem_write;
                commit.value     <= head_entry.value;
                commit.addr      <= head_entry.addr;   // Store address for memory
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            trap <= 1'b0;
            mret <= 1'b0;
        end else begin
            trap <= flush_all;
            mret <= is_mret;
            if (flush_all) begin
                epc   <= head_entry.pc;                // Held until the next trap
                cause <= head_entry.cause;
            end
        end
    end

    // x0 stays hardwired to zero
    always_ff @(posedge clk) begin
        if (is_normal && head_entry.reg_write && (head_entry.rd != 5'd0)) begin
            arf[head_entry.rd] <= head_entry.value;
        end
    end

    a_trap_excl_commit: assert property (
        @(posedge clk) disable iff (rst)
        !(trap && commit.valid)
    ) else $error("trap and commit in the same cycle");

endmodule

`default_nettype wire

//--- rob_buffer.sv
`default_nettype none

module rob_buffer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       alloc_valid,
    input  rob_pkg::rob_entry_t        alloc_entry,
    input  rob_pkg::exec_result_t      alu_result,
    input  rob_pkg::exec_result_t      lsu_result,
    input  rob_pkg::redirect_t         redirect,
    input  logic                       retire,
    input  logic                       flush_all,
    output logic [rob_pkg::TAG_W-1:0]  alloc_tag,
    output logic                       rob_full,
    output rob_pkg::rob_entry_t        head_entry
);

    rob_pkg::rob_entry_t entries [rob_pkg::ROB_DEPTH];  // Circular slot store

    rob_pkg::tag_t head;        // Oldest entry
    rob_pkg::tag_t tail;        // Next free slot
    rob_pkg::cnt_t count;       // Live entries
    rob_pkg::cnt_t count_base;  // Count after alloc or truncation
    rob_pkg::cnt_t count_next;
    rob_pkg::tag_t br_off;      // Branch distance from head

    logic [rob_pkg::ROB_DEPTH-1:0] alu_hit;  // Per-slot completion match
    logic [rob_pkg::ROB_DEPTH-1:0] lsu_hit;
    logic [rob_pkg::ROB_DEPTH-1:0] younger;  // Behind the redirected branch

    assign alloc_tag  = tail;  // Tag handed out in the dispatch cycle
    assign rob_full   = (count == rob_pkg::cnt_t'(rob_pkg::ROB_DEPTH));
    assign head_entry = entries[head];

    assign br_off = redirect.tag - head;

    // Slot match vectors
    always_comb begin
        for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
            alu_hit[i] = alu_result.done && entries[i].busy &&
                         (alu_result.tag == rob_pkg::tag_t'(i));  // Stale tags fall out here
            lsu_hit[i] = lsu_result.done && entries[i].busy &&
                         (lsu_result.tag == rob_pkg::tag_t'(i));
            younger[i] = entries[i].busy &&
                         ((rob_pkg::tag_t'(i) - head) > br_off);  // Age by distance from head
        end
    end

    // Occupancy
    always_comb begin
        if (redirect.valid) begin
            count_base = {1'b0, br_off} + rob_pkg::cnt_t'(1);  // Head through branch
        end else begin
            count_base = count + {{rob_pkg::TAG_W{1'b0}}, alloc_valid};
        end
        count_next = count_base - {{rob_pkg::TAG_W{1'b0}}, retire};
    end

    always_ff @(posedge clk) begin
        if (rst || flush_all) begin  // Trap flush wins over everything
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                entries[i].busy  <= 1'b0;
                entries[i].ready <= 1'b0;
            end
        end else begin
            for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
                if (alu_hit[i]) begin
                    entries[i].value     <= alu_result.value;
                    entries[i].addr      <= alu_result.addr;
                    entries[i].exception <= alu_result.exception;
                    entries[i].cause     <= alu_result.cause;
                    entries[i].ready     <= 1'b1;
                end
                if (lsu_hit[i]) begin
                    entries[i].value     <= lsu_result.value;
                    entries[i].addr      <= lsu_result.addr;
                    entries[i].exception <= lsu_result.exception;
                    entries[i].cause     <= lsu_result.cause;
                    entries[i].ready     <= 1'b1;
                end
                if (redirect.valid && younger[i]) begin
                    entries[i].busy  <= 1'b0;  // Wrong-path, squash
                    entries[i].ready <= 1'b0;
                end
            end
            if (redirect.valid) begin
                entries[redirect.tag].value <= redirect.target;  // Branch commits its target
                entries[redirect.tag].ready <= 1'b1;
                tail <= redirect.tag + rob_pkg::tag_t'(1);       // Same-cycle dispatch lost
            end else if (alloc_valid) begin
                entries[tail] <= alloc_entry;
                tail          <= tail + rob_pkg::tag_t'(1);
            end
            if (retire) begin
                entries[head].busy  <= 1'b0;  // Pop oldest
                entries[head].ready <= 1'b0;
                head                <= head + rob_pkg::tag_t'(1);
            end
            count <= count_next;
        end
    end

    // Execution units never finish the same instruction twice in one cycle
    a_distinct_tags: assert property (
        @(posedge clk) disable iff (rst)
        (alu_result.done && lsu_result.done) |-> (alu_result.tag != lsu_result.tag)
    ) else $error("alu and lsu report the same tag");

    // Commit may only pop a live, finished head
    a_retire_ready: assert property (
        @(posedge clk) disable iff (rst)
        retire |-> (head_entry.busy && head_entry.ready)
    ) else $error("retire of a head that is not busy and ready");

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= rob_pkg::cnt_t'(rob_pkg::ROB_DEPTH)
    ) else $error("occupancy above ROB_DEPTH");

endmodule

`default_nettype wire

//--- dispatch_unit.sv
`default_nettype none

module dispatch_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      inst_valid,
    input  logic [rob_pkg::XLEN-1:0]  inst,
    input  logic [rob_pkg::XLEN-1:0]  pc,
    input  logic                      rob_full,
    output logic                      alloc_valid,
    output rob_pkg::rob_entry_t       alloc_entry
);

    rob_pkg::opcode_e op;  // Decoded class

    // Major opcode to instruction class
    always_comb begin
        if (inst == rob_pkg::MRET_INST) begin  // Whole word match, not just SYSTEM
            op = rob_pkg::OP_MRET;
        end else begin
            case (inst[6:0])
                rob_pkg::OPC_LUI,
                rob_pkg::OPC_AUIPC,
                rob_pkg::OPC_OP_IMM,
                rob_pkg::OPC_OP:     op = rob_pkg::OP_ALU;
                rob_pkg::OPC_LOAD:   op = rob_pkg::OP_LOAD;
                rob_pkg::OPC_STORE:  op = rob_pkg::OP_STORE;
                rob_pkg::OPC_BRANCH,
                rob_pkg::OPC_JAL,
                rob_pkg::OPC_JALR:   op = rob_pkg::OP_BRANCH;
                default:             op = rob_pkg::OP_ILLEGAL;  // Other SYSTEM too
            endcase
        end
    end

    assign alloc_valid = inst_valid && !rob_full;  // Dropped while the buffer is full

    always_comb begin
        alloc_entry           = '0;                 // Value and addr filled at completion
        alloc_entry.busy      = 1'b1;
        alloc_entry.opcode    = op;
        alloc_entry.rd        = inst[11:7];         // Raw field, ignored unless reg_write
        alloc_entry.pc        = pc;
        alloc_entry.reg_write = (op == rob_pkg::OP_ALU) || (op == rob_pkg::OP_LOAD);
        alloc_entry.mem_write = (op == rob_pkg::OP_STORE);
        alloc_entry.cause     = rob_pkg::CAUSE_ILLEGAL;
        if (op == rob_pkg::OP_ILLEGAL) begin
            alloc_entry.ready     = 1'b1;           // Decode exception, nothing to execute
            alloc_entry.exception = 1'b1;
        end
        if (op == rob_pkg::OP_MRET) begin
            alloc_entry.ready = 1'b1;               // No unit reports for mret
        end
    end

    // Upstream must hold off dispatch while the buffer reports full
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (rst)
        inst_valid |-> !rob_full
    ) else $error("dispatch presented while rob_full is high");

endmodule

`default_nettype wire

//--- rob_pkg.sv
`default_nettype none

package rob_pkg;

    localparam int ROB_DEPTH = 16;                 // Buffer entries
    localparam int TAG_W     = $clog2(ROB_DEPTH);  // 4-bit tag
    localparam int CNT_W     = TAG_W + 1;          // Occupancy counts up to ROB_DEPTH
    localparam int XLEN      = 32;                 // Data and address width

    // RV32 major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    localparam logic [XLEN-1:0] MRET_INST = 32'h3020_0073;  // Full mret encoding

    typedef logic [TAG_W-1:0] tag_t;  // Buffer slot index
    typedef logic [CNT_W-1:0] cnt_t;  // Occupancy

    typedef enum logic [2:0] {
        OP_ALU,      // Integer ops, lui, auipc
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,   // Conditional branches and jumps
        OP_MRET,
        OP_ILLEGAL   // Unknown encoding, traps at commit
    } opcode_e;

    typedef enum logic [1:0] {
        CAUSE_ILLEGAL,
        CAUSE_DIV_ZERO,
        CAUSE_MEM_FAULT
    } cause_e;

    typedef struct packed {
        logic            busy;       // Slot holds a live instruction
        logic            ready;      // Result present, may retire
        opcode_e         opcode;
        logic            reg_write;  // Writes rd at commit
        logic            mem_write;  // Store, addr reported at commit
        logic [4:0]      rd;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] value;      // Result, or target for a branch
        logic [XLEN-1:0] addr;       // Memory address from the LSU
        logic            exception;
        cause_e          cause;
    } rob_entry_t;                   // 111 bits

    typedef struct packed {
        logic            done;       // Report valid this cycle
        tag_t            tag;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] addr;
        logic            exception;
        cause_e          cause;
    } exec_result_t;                 // 72 bits

    typedef struct packed {
        logic            valid;      // Misprediction this cycle
        tag_t            tag;        // Tag of the branch
        logic [XLEN-1:0] target;     // Corrected target
    } redirect_t;                    // 37 bits

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            reg_write;
        logic            mem_write;
        logic [XLEN-1:0] value;
        logic [XLEN-1:0] addr;
    } commit_t;                      // 72 bits

endpackage

`default_nettype wire
